//--- project.f
+incdir+.
trace_pkg.sv
trace_capture.sv
trace_stage_tracker.sv
trace_retire_buffer.sv
trace_unit_top.sv
tb_trace_unit.sv

//--- run_sim.sh
#!/bin/sh
# Build the trace unit testbench with Verilator and run it
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_trace_unit \
  -f project.f -o tb_trace_unit &&
out="$(./obj_dir/tb_trace_unit)" &&
printf '%s\n' "$out" &&
printf '%s\n' "$out" | grep -q "Finished with no errors" &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }

//--- tb_trace_unit.sv
/* Trace unit testbench
   Random pipeline traffic checked against a queue model of retire records */
`timescale 1ns/10ps
`include "trace_macros.svh"

module tb_trace_unit;

  localparam int clk_period  = 10;
  localparam int num_insns   = 200;
  localparam int flood_insns = `TRACE_DEPTH + 1;

  localparam logic [6:0] opc_alu   = 7'b0110011;
  localparam logic [6:0] opc_store = 7'b0100011;

  logic                   clk_i;
  logic                   rst_n;
  trace_pkg::decode_evt_t decode_i;
  trace_pkg::ex_evt_t     ex_i;
  trace_pkg::mem_evt_t    mem_i;
  trace_pkg::wb_evt_t     wb_i;
  trace_pkg::trace_rec_t  trace_o;
  logic                   trace_valid_o;
  logic                   overflow_o;

  integer                 seed = 13793;
  int                     errors;
  int                     checks;
  logic                   flooding;
  logic [`TRACE_XLEN-1:0] next_pc;
  trace_pkg::trace_rec_t  exp_q[$];
  trace_pkg::trace_rec_t  head_rec;

  trace_unit_top dut0 (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .decode_i      (decode_i),
    .ex_i          (ex_i),
    .mem_i         (mem_i),
    .wb_i          (wb_i),
    .trace_o       (trace_o),
    .trace_valid_o (trace_valid_o),
    .overflow_o    (overflow_o)
  );

  always #(clk_period / 2) clk_i = ~clk_i;

  function automatic int unsigned pick_below(int unsigned n);
    int unsigned r;
    r = $random(seed);
    return r % n;
  endfunction

  function automatic logic [31:0] random_word();
    return $random(seed);
  endfunction

  // Granted data access at a random address
  function automatic trace_pkg::mem_evt_t mem_grant(logic we);
    trace_pkg::mem_evt_t m;
    m       = '0;
    m.req   = 1'b1;
    m.gnt   = 1'b1;
    m.we    = we;
    m.addr  = random_word();
    m.wdata = random_word();
    return m;
  endfunction

  // All core strobes change together just after the edge
  task automatic drive_cycle(trace_pkg::decode_evt_t d, trace_pkg::ex_evt_t e,
                             trace_pkg::mem_evt_t m, trace_pkg::wb_evt_t w);
    @(posedge clk_i);
    decode_i <= d;
    ex_i     <= e;
    mem_i    <= m;
    wb_i     <= w;
  endtask

  task automatic insert_stalls();
    repeat (pick_below(3)) drive_cycle('0, '0, '0, '0);
  endtask

  // Bypassed ALU op that retires ahead of an older APU op still in execute delay
  task automatic run_bypass_behind(output trace_pkg::trace_rec_t rec);
    trace_pkg::decode_evt_t d;
    trace_pkg::ex_evt_t     e;
    logic [31:0]            r;

    r             = random_word();
    d             = '0;
    e             = '0;
    rec           = '0;
    d.valid       = 1'b1;
    d.pc          = next_pc;
    d.instr       = {r[31:7], opc_alu};
    next_pc       = next_pc + 4;
    rec.pc        = d.pc;
    rec.instr     = d.instr;
    rec.wb_bypass = 1'b1;
    drive_cycle(d, '0, '0, '0);

    insert_stalls();
    e.valid     = 1'b1;
    e.wb_bypass = 1'b1;
    if (r[0]) begin
      e.reg_we      = 1'b1;
      e.reg_addr    = r[6:1];
      e.reg_wdata   = random_word();
      rec.reg_valid = 1'b1;
      rec.reg_addr  = e.reg_addr;
      rec.reg_data  = e.reg_wdata;
    end
    drive_cycle('0, e, '0, '0);
  endtask

  // ------------------------------
  // Scripted pipeline driver
  // ------------------------------
  task automatic run_instruction();
    trace_pkg::decode_evt_t d;
    trace_pkg::ex_evt_t     e;
    trace_pkg::mem_evt_t    m;
    trace_pkg::wb_evt_t     w;
    trace_pkg::trace_rec_t  exp;
    trace_pkg::trace_rec_t  exp_byp;
    logic [31:0]            r;
    logic [31:0]            v;
    int unsigned            kind;
    logic                   misal;
    logic                   overtake;

    // 0 alu, 1 load, 2 store, 3 apu, 4 extra writeback, 5 illegal, 6 bypass
    kind     = pick_below(7);
    r        = random_word();
    v        = random_word();
    misal    = (kind == 1 || kind == 2) && (pick_below(4) == 0);
    overtake = 1'b0;
    d        = '0;
    e        = '0;
    m        = '0;
    w        = '0;
    exp      = '0;
    exp_byp  = '0;
    d.valid  = 1'b1;
    d.pc     = next_pc;
    next_pc  = next_pc + 4;
    case (kind)
      0: begin
        d.compressed = r[0];
        d.instr      = r[0] ? {16'h0, r[15:2], 2'b01} : {r[31:7], opc_alu};
      end
      1: begin
        d.compressed = r[0];
        exp.is_load  = 1'b1;
        d.instr      = r[0] ? {16'h0, 3'b010, r[12:2], 2'b00} : {r[31:7], `TRACE_OPC_LOAD};
      end
      2: d.instr = {r[31:7], opc_store};
      3: begin
        exp.is_apu = 1'b1;
        d.instr    = {r[31:7], `TRACE_OPC_FP};
      end
      4: begin
        exp.delay_class = 1'b1;
        d.compressed    = (r[1:0] == 2'd3);
        case (r[1:0])
          2'd0:    d.instr = `TRACE_INSN_MRET;
          2'd1:    d.instr = `TRACE_INSN_URET;
          2'd2:    d.instr = `TRACE_INSN_EBREAK;
          default: d.instr = {16'h0, `TRACE_INSN_CEBREAK};
        endcase
      end
      5: begin
        d.illegal = 1'b1;
        d.instr   = r;
      end
      default: begin
        exp.wb_bypass = 1'b1;
        d.instr       = {r[31:7], opc_alu};
      end
    endcase
    exp.pc         = d.pc;
    exp.instr      = d.instr;
    exp.compressed = d.compressed;
    drive_cycle(d, '0, '0, '0);
    if (kind == 5) begin
      return;
    end

    // A misaligned access holds execute for one extra cycle
    insert_stalls();
    e.valid = 1'b1;
    if (kind == 1 || kind == 2) begin
      m             = mem_grant(kind == 2);
      exp.mem_valid = 1'b1;
      exp.mem_we    = m.we;
      exp.mem_addr  = m.addr;
      exp.mem_wdata = m.we ? m.wdata : '0;
      if (misal) begin
        e.misaligned   = 1'b1;
        exp.misaligned = 1'b1;
        drive_cycle('0, e, m, '0);
        e.misaligned = 1'b0;
        m.addr       = m.addr + 4;
        m.wdata      = random_word();
      end
    end
    if ((kind == 0 || kind == 6) && v[31]) begin
      e.reg_we      = 1'b1;
      e.reg_addr    = v[5:0];
      e.reg_wdata   = random_word();
      exp.reg_valid = 1'b1;
      exp.reg_addr  = e.reg_addr;
      exp.reg_data  = e.reg_wdata;
    end
    e.apu_en    = (kind == 3);
    e.wb_bypass = (kind == 6);
    drive_cycle('0, e, m, '0);
    if (kind == 6) begin
      exp_q.push_back(exp);
      return;
    end

    // APU result comes back while the instruction sits in execute delay
    if (kind == 3) begin
      insert_stalls();
      overtake = (pick_below(2) == 0);
      if (overtake) begin
        run_bypass_behind(exp_byp);
      end
      e             = '0;
      e.apu_rvalid  = 1'b1;
      e.reg_we      = 1'b1;
      e.reg_addr    = v[5:0];
      e.reg_wdata   = random_word();
      exp.reg_valid = 1'b1;
      exp.reg_addr  = e.reg_addr;
      exp.reg_data  = e.reg_wdata;
      drive_cycle('0, e, '0, '0);
    end

    insert_stalls();
    w.valid = 1'b1;
    if (kind == 1) begin
      w.reg_we      = 1'b1;
      w.reg_addr    = v[11:6];
      w.reg_wdata   = random_word();
      exp.reg_valid = 1'b1;
      exp.reg_addr  = w.reg_addr;
      exp.reg_data  = w.reg_wdata;
    end
    drive_cycle('0, '0, '0, w);
    exp_q.push_back(exp);
    // The younger bypassed op waits behind the APU op
    if (overtake) begin
      exp_q.push_back(exp_byp);
    end
  endtask

  // ------------------------------
  // Output monitor
  // ------------------------------
  always @(negedge clk_i) begin
    if (rst_n && trace_valid_o) begin
      assert (exp_q.size() > 0) else begin
        $display("Record at %0t has no pending instruction to match", $time);
        errors++;
      end
      if (exp_q.size() > 0) begin
        head_rec = exp_q.pop_front();
        checks++;
        assert (trace_o == head_rec) else begin
          $display("Mismatch at %0t: record for pc %h got %h expected %h", $time,
                   head_rec.pc, trace_o, head_rec);
          errors++;
        end
      end
    end
    if (rst_n && !flooding) begin
      assert (!overflow_o) else begin
        $display("Mismatch at %0t: overflow_o high during normal traffic", $time);
        errors++;
      end
    end
  end

  initial begin
    #(clk_period * 40 * (num_insns + flood_insns + 1));
    $display("Timeout: the run did not reach its end in time");
    $display("Finished with errors");
    $finish;
  end

  initial begin
    trace_pkg::decode_evt_t flood_dec;
    int                     phase_errors;

    clk_i    = 1'b0;
    rst_n    = 1'b0;
    decode_i = '0;
    ex_i     = '0;
    mem_i    = '0;
    wb_i     = '0;
    errors   = 0;
    checks   = 0;
    flooding = 1'b0;
    next_pc  = 32'h0000_1000;
    repeat (4) @(posedge clk_i);
    rst_n <= 1'b1;

    for (int i = 0; i < num_insns; i++) begin
      run_instruction();
    end
    while (exp_q.size() > 0) begin
      drive_cycle('0, '0, '0, '0);
    end
    $display("Test random_traffic done: %0d records checked, %0d errors", checks, errors);

    // Fill every slot with nothing retiring, then one decode more
    flooding        = 1'b1;
    phase_errors    = errors;
    flood_dec       = '0;
    flood_dec.valid = 1'b1;
    flood_dec.instr = {25'h0, opc_alu};
    for (int i = 0; i < flood_insns; i++) begin
      flood_dec.pc = next_pc;
      next_pc      = next_pc + 4;
      drive_cycle(flood_dec, '0, '0, '0);
    end
    drive_cycle('0, '0, '0, '0);
    @(negedge clk_i);
    checks++;
    assert (overflow_o) else begin
      $display("Mismatch at %0t: overflow_o low after flooding decode", $time);
      errors++;
    end
    $display("Test overflow_flood done: %0d errors", errors - phase_errors);

    $display("Checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- trace_capture.sv
/* Trace capture
   Qualifies legal decodes, classifies them and allocates a buffer slot */
`timescale 1ns/10ps
`include "trace_macros.svh"

module trace_capture (
  input  logic                  clk_i,
  input  logic                  rst_n,
  input  trace_pkg::decode_evt_t decode_i,
  output logic                  new_valid_o,
  output trace_pkg::tag_t       new_tag_o,
  output trace_pkg::trace_rec_t new_rec_o
);

  trace_pkg::tag_t alloc_q;
  logic [6:0]      opcode;
  logic            c_load;

  assign new_valid_o = decode_i.valid && !decode_i.illegal;
  assign new_tag_o   = alloc_q;
  assign opcode      = decode_i.instr[6:0];

  // c.lw and c.lwsp
  assign c_load = (decode_i.instr[15:13] == 3'b010) &&
                  ((decode_i.instr[1:0] == 2'b00) || (decode_i.instr[1:0] == 2'b10));

  // ------------------------------
  // Record build
  // ------------------------------
  always_comb begin
    new_rec_o            = '0;
    new_rec_o.pc         = decode_i.pc;
    new_rec_o.instr      = decode_i.instr;
    new_rec_o.compressed = decode_i.compressed;
    if (decode_i.compressed) begin
      new_rec_o.is_load     = c_load;
      new_rec_o.delay_class = (decode_i.instr[15:0] == `TRACE_INSN_CEBREAK);
    end else begin
      new_rec_o.is_load     = (opcode == `TRACE_OPC_LOAD);
      new_rec_o.is_apu      = (opcode == `TRACE_OPC_FP);
      new_rec_o.delay_class = (decode_i.instr == `TRACE_INSN_MRET) ||
                              (decode_i.instr == `TRACE_INSN_URET) ||
                              (decode_i.instr == `TRACE_INSN_EBREAK);
    end
  end

  // One slot allocated per legal decode
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      alloc_q <= '0;
    end else if (new_valid_o) begin
      if (alloc_q == trace_pkg::tag_t'(`TRACE_DEPTH - 1)) begin
        alloc_q <= '0;
      end else begin
        alloc_q <= alloc_q + 1'b1;
      end
    end
  end

endmodule

//--- trace_macros.svh
/* Trace unit constants
   Buffer depth, data widths and the encodings the tracer classifies on */
`ifndef TRACE_MACROS_SVH
`define TRACE_MACROS_SVH

// Ring buffer of pending records
`define TRACE_DEPTH 8
`define TRACE_TAG_W $clog2(`TRACE_DEPTH)

// Data, address and register index widths
`define TRACE_XLEN 32
`define TRACE_REG_AW 6

// Major opcodes
`define TRACE_OPC_LOAD 7'b0000011
`define TRACE_OPC_FP 7'b1010011

// Instructions that take one extra writeback cycle
`define TRACE_INSN_MRET 32'h3020_0073
`define TRACE_INSN_URET 32'h0020_0073
`define TRACE_INSN_EBREAK 32'h0010_0073
`define TRACE_INSN_CEBREAK 16'h9002

// Stage slots in the tag and flag vectors
`define TRACE_STAGES 4
`define TRACE_STG_EX 0
`define TRACE_STG_EXD 1
`define TRACE_STG_WB 2
`define TRACE_STG_WBD 3
`define TRACE_MARKS 3

`endif

//--- trace_pkg.sv
/* Trace unit types
   Pipeline event bundles, retire records and annotation strobes */
`include "trace_macros.svh"

package trace_pkg;

  typedef logic [`TRACE_TAG_W-1:0] tag_t;

  // ------------------------------
  // Core strobes
  // ------------------------------
  typedef struct packed {
    logic                   valid;
    logic                   illegal;
    logic                   compressed;
    logic [`TRACE_XLEN-1:0] pc;
    logic [`TRACE_XLEN-1:0] instr;
  } decode_evt_t;

  typedef struct packed {
    logic                     valid;
    logic                     misaligned;
    logic                     wb_bypass;
    logic                     apu_en;
    logic                     apu_rvalid;
    logic                     reg_we;
    logic [`TRACE_REG_AW-1:0] reg_addr;
    logic [`TRACE_XLEN-1:0]   reg_wdata;
  } ex_evt_t;

  typedef struct packed {
    logic                   req;
    logic                   gnt;
    logic                   we;
    logic [`TRACE_XLEN-1:0] addr;
    logic [`TRACE_XLEN-1:0] wdata;
  } mem_evt_t;

  typedef struct packed {
    logic                     valid;
    logic                     reg_we;
    logic [`TRACE_REG_AW-1:0] reg_addr;
    logic [`TRACE_XLEN-1:0]   reg_wdata;
  } wb_evt_t;

  // ------------------------------
  // Records and annotations
  // ------------------------------
  typedef struct packed {
    logic [`TRACE_XLEN-1:0]   pc;
    logic [`TRACE_XLEN-1:0]   instr;
    logic                     compressed;
    logic                     is_load;
    logic                     is_apu;
    logic                     delay_class;
    logic                     wb_bypass;
    logic                     misaligned;
    logic                     reg_valid;
    logic [`TRACE_REG_AW-1:0] reg_addr;
    logic [`TRACE_XLEN-1:0]   reg_data;
    logic                     mem_valid;
    logic                     mem_we;
    logic [`TRACE_XLEN-1:0]   mem_addr;
    logic [`TRACE_XLEN-1:0]   mem_wdata;
  } trace_rec_t;

  typedef enum logic [2:0] {
    ANNOT_REG,
    ANNOT_MEM,
    ANNOT_BYPASS,
    ANNOT_MISAL,
    ANNOT_RETIRE
  } annot_kind_e;

  typedef struct packed {
    logic                     valid;
    annot_kind_e              kind;
    tag_t                     tag;
    logic [`TRACE_REG_AW-1:0] reg_addr;
    logic [`TRACE_XLEN-1:0]   reg_data;
    logic                     mem_we;
    logic [`TRACE_XLEN-1:0]   mem_addr;
    logic [`TRACE_XLEN-1:0]   mem_wdata;
  } annot_t;

  // Per-stage record flags returned by the buffer
  typedef struct packed {
    logic is_load;
    logic is_apu;
    logic delay_class;
    logic reg_valid;
  } stage_flags_t;

endpackage

//--- trace_retire_buffer.sv
/* Trace retire buffer
   Ring of pending records, merges annotations and drains retired heads in order */
`timescale 1ns/10ps
`include "trace_macros.svh"

module trace_retire_buffer (
  input  logic                                        clk_i,
  input  logic                                        rst_n,
  input  logic                                        new_valid_i,
  input  trace_pkg::tag_t                             new_tag_i,
  input  trace_pkg::trace_rec_t                       new_rec_i,
  input  trace_pkg::annot_t                           annot_ex_i,
  input  trace_pkg::annot_t                           annot_wb_i,
  input  trace_pkg::annot_t                           annot_mem_i,
  input  trace_pkg::annot_t [`TRACE_MARKS-1:0]         annot_mark_i,
  input  trace_pkg::tag_t [`TRACE_STAGES-1:0]          stage_tags_i,
  output trace_pkg::stage_flags_t [`TRACE_STAGES-1:0] stage_flags_o,
  output trace_pkg::trace_rec_t                       trace_o,
  output logic                                        trace_valid_o,
  output logic                                        overflow_o
);

  localparam int NumAnnot = `TRACE_MARKS + 3;

  trace_pkg::trace_rec_t      rec_q [`TRACE_DEPTH];
  logic [`TRACE_DEPTH-1:0]    busy_q, retired_q;
  trace_pkg::tag_t            head_q;
  logic                       overflow_q, trace_valid_q;
  trace_pkg::trace_rec_t      trace_q;
  trace_pkg::annot_t          annots [NumAnnot];
  logic                       alloc_ok, drain;

  assign alloc_ok      = new_valid_i && !busy_q[new_tag_i];
  assign drain         = busy_q[head_q] && retired_q[head_q];
  assign trace_o       = trace_q;
  assign trace_valid_o = trace_valid_q;
  assign overflow_o    = overflow_q;

  // Later entries win on the same field
  always_comb begin
    annots[0] = annot_ex_i;
    annots[1] = annot_wb_i;
    annots[2] = annot_mem_i;
    for (int i = 0; i < `TRACE_MARKS; i++) begin
      annots[3+i] = annot_mark_i[i];
    end
  end

  always_comb begin
    for (int s = 0; s < `TRACE_STAGES; s++) begin
      stage_flags_o[s].is_load     = rec_q[stage_tags_i[s]].is_load;
      stage_flags_o[s].is_apu      = rec_q[stage_tags_i[s]].is_apu;
      stage_flags_o[s].delay_class = rec_q[stage_tags_i[s]].delay_class;
      stage_flags_o[s].reg_valid   = rec_q[stage_tags_i[s]].reg_valid;
    end
  end

  // ------------------------------
  // Record storage
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (alloc_ok) begin
      rec_q[new_tag_i] <= new_rec_i;
    end
    for (int i = 0; i < NumAnnot; i++) begin
      if (annots[i].valid) begin
        case (annots[i].kind)
          trace_pkg::ANNOT_REG: begin
            rec_q[annots[i].tag].reg_valid <= 1'b1;
            rec_q[annots[i].tag].reg_addr  <= annots[i].reg_addr;
            rec_q[annots[i].tag].reg_data  <= annots[i].reg_data;
          end
          trace_pkg::ANNOT_MEM: begin
            // First access only
            if (!rec_q[annots[i].tag].mem_valid) begin
              rec_q[annots[i].tag].mem_valid <= 1'b1;
              rec_q[annots[i].tag].mem_we    <= annots[i].mem_we;
              rec_q[annots[i].tag].mem_addr  <= annots[i].mem_addr;
              rec_q[annots[i].tag].mem_wdata <= annots[i].mem_we ? annots[i].mem_wdata : '0;
            end
          end
          trace_pkg::ANNOT_BYPASS: rec_q[annots[i].tag].wb_bypass <= 1'b1;
          trace_pkg::ANNOT_MISAL:  rec_q[annots[i].tag].misaligned <= 1'b1;
          default: ;
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (drain) begin
      trace_q <= rec_q[head_q];
    end
  end

  // ------------------------------
  // Slot state and drain
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      busy_q        <= '0;
      retired_q     <= '0;
      head_q        <= '0;
      overflow_q    <= 1'b0;
      trace_valid_q <= 1'b0;
    end else begin
      trace_valid_q <= drain;
      if (drain) begin
        busy_q[head_q]    <= 1'b0;
        retired_q[head_q] <= 1'b0;
        if (head_q == trace_pkg::tag_t'(`TRACE_DEPTH - 1)) begin
          head_q <= '0;
        end else begin
          head_q <= head_q + 1'b1;
        end
      end
      if (alloc_ok) begin
        busy_q[new_tag_i]    <= 1'b1;
        retired_q[new_tag_i] <= 1'b0;
      end
      // Sticky until reset
      if (new_valid_i && busy_q[new_tag_i]) begin
        overflow_q <= 1'b1;
      end
      for (int i = 0; i < `TRACE_MARKS; i++) begin
        if (annot_mark_i[i].valid && (annot_mark_i[i].kind == trace_pkg::ANNOT_RETIRE ||
                                      annot_mark_i[i].kind == trace_pkg::ANNOT_BYPASS)) begin
          retired_q[annot_mark_i[i].tag] <= 1'b1;
        end
      end
    end
  end

  // Allocation runs into a busy slot only once every slot is pending
  a_alloc_only_when_full: assert property (@(posedge clk_i) disable iff (!rst_n || overflow_q)
    new_valid_i && busy_q[new_tag_i] |-> &busy_q);

  for (genvar m = 0; m < `TRACE_MARKS; m++) begin : g_mark_chk
    a_mark_hits_busy: assert property (@(posedge clk_i) disable iff (!rst_n)
      annot_mark_i[m].valid |-> busy_q[annot_mark_i[m].tag]);
  end

endmodule

//--- trace_stage_tracker.sv
/* Trace stage tracker
   Follows record tags through EX, EX delay, WB and WB delay and attributes
   register writes, memory accesses and retirement to them */
`timescale 1ns/10ps
`include "trace_macros.svh"

module trace_stage_tracker (
  input  logic                                       clk_i,
  input  logic                                       rst_n,
  input  logic                                       new_valid_i,
  input  trace_pkg::tag_t                            new_tag_i,
  input  trace_pkg::ex_evt_t                         ex_i,
  input  trace_pkg::mem_evt_t                        mem_i,
  input  trace_pkg::wb_evt_t                         wb_i,
  input  trace_pkg::stage_flags_t [`TRACE_STAGES-1:0] stage_flags_i,
  output trace_pkg::annot_t                          annot_ex_o,
  output trace_pkg::annot_t                          annot_wb_o,
  output trace_pkg::annot_t                          annot_mem_o,
  output trace_pkg::annot_t [`TRACE_MARKS-1:0]        annot_mark_o,
  output trace_pkg::tag_t [`TRACE_STAGES-1:0]         stage_tags_o
);

  logic            ex_occ_q, exd_occ_q, wb_occ_q, wbd_occ_q;
  trace_pkg::tag_t ex_tag_q, exd_tag_q, wb_tag_q, wbd_tag_q;

  trace_pkg::stage_flags_t fl_exd, fl_wb;

  logic wb_leave, wb_to_wbd, wb_retire;
  logic exd_to_wb;
  logic ex_misal, ex_bypass, ex_to_exd, ex_to_wb, ex_clear;
  logic ex_port_ok, exd_takes_ex;

  assign fl_exd = stage_flags_i[`TRACE_STG_EXD];
  assign fl_wb  = stage_flags_i[`TRACE_STG_WB];

  assign stage_tags_o[`TRACE_STG_EX]  = ex_tag_q;
  assign stage_tags_o[`TRACE_STG_EXD] = exd_tag_q;
  assign stage_tags_o[`TRACE_STG_WB]  = wb_tag_q;
  assign stage_tags_o[`TRACE_STG_WBD] = wbd_tag_q;

  function automatic trace_pkg::annot_t mk_annot(logic valid, trace_pkg::annot_kind_e kind,
                                                 trace_pkg::tag_t tag);
    trace_pkg::annot_t a;
    a       = '0;
    a.valid = valid;
    a.kind  = kind;
    a.tag   = tag;
    return a;
  endfunction

  // ------------------------------
  // Stage moves
  // ------------------------------
  always_comb begin
    wb_leave  = wb_occ_q && wb_i.valid;
    wb_to_wbd = wb_leave && fl_wb.delay_class;
    wb_retire = wb_leave && !fl_wb.delay_class;

    // Non-APU instructions leave EX delay at once
    exd_to_wb = exd_occ_q && (ex_i.apu_rvalid || !fl_exd.is_apu);

    ex_misal  = 1'b0;
    ex_bypass = 1'b0;
    ex_to_exd = 1'b0;
    ex_to_wb  = 1'b0;
    if (ex_occ_q && ex_i.valid && ex_i.misaligned) begin
      ex_misal = 1'b1;
    end else if (ex_occ_q && ex_i.wb_bypass) begin
      ex_bypass = 1'b1;
    end else if (ex_occ_q && ex_i.apu_en && !ex_i.apu_rvalid) begin
      ex_to_exd = 1'b1;
    end else if (ex_occ_q && ex_i.valid) begin
      // WB port already taken by EX delay
      if (exd_to_wb) begin
        ex_to_exd = 1'b1;
      end else begin
        ex_to_wb = 1'b1;
      end
    end
    ex_clear = ex_bypass || ex_to_exd || ex_to_wb;
  end

  // ------------------------------
  // Attribution
  // ------------------------------
  assign ex_port_ok   = ex_i.reg_we && (ex_i.valid || !wb_i.valid || ex_i.apu_rvalid);
  assign exd_takes_ex = exd_occ_q && !fl_exd.reg_valid && !fl_exd.is_load &&
                        (fl_exd.is_apu ? ex_i.apu_rvalid : (ex_i.valid || !wb_i.valid));

  always_comb begin
    annot_ex_o = mk_annot(ex_port_ok && (exd_takes_ex || ex_occ_q), trace_pkg::ANNOT_REG,
                          exd_takes_ex ? exd_tag_q : ex_tag_q);
    annot_ex_o.reg_addr = ex_i.reg_addr;
    annot_ex_o.reg_data = ex_i.reg_wdata;

    // Loads parked in EX delay own the WB port first
    if (wb_i.reg_we && exd_occ_q && fl_exd.is_load) begin
      annot_wb_o = mk_annot(1'b1, trace_pkg::ANNOT_REG, exd_tag_q);
    end else begin
      annot_wb_o = mk_annot(wb_i.reg_we && wb_occ_q && !fl_wb.reg_valid &&
                            (!fl_wb.is_load || wb_i.valid), trace_pkg::ANNOT_REG, wb_tag_q);
    end
    annot_wb_o.reg_addr = wb_i.reg_addr;
    annot_wb_o.reg_data = wb_i.reg_wdata;

    annot_mem_o = mk_annot(mem_i.req && mem_i.gnt && ex_occ_q, trace_pkg::ANNOT_MEM, ex_tag_q);
    annot_mem_o.mem_we    = mem_i.we;
    annot_mem_o.mem_addr  = mem_i.addr;
    annot_mem_o.mem_wdata = mem_i.wdata;

    annot_mark_o[0] = mk_annot(wbd_occ_q, trace_pkg::ANNOT_RETIRE, wbd_tag_q);
    annot_mark_o[1] = mk_annot(wb_retire, trace_pkg::ANNOT_RETIRE, wb_tag_q);
    annot_mark_o[2] = mk_annot(ex_misal || ex_bypass,
                               ex_misal ? trace_pkg::ANNOT_MISAL : trace_pkg::ANNOT_BYPASS,
                               ex_tag_q);
  end

  // ------------------------------
  // Stage registers
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_n) begin
    if (!rst_n) begin
      ex_occ_q  <= 1'b0;
      exd_occ_q <= 1'b0;
      wb_occ_q  <= 1'b0;
      wbd_occ_q <= 1'b0;
      ex_tag_q  <= '0;
      exd_tag_q <= '0;
      wb_tag_q  <= '0;
      wbd_tag_q <= '0;
    end else begin
      if (new_valid_i) begin
        ex_occ_q <= 1'b1;
        ex_tag_q <= new_tag_i;
      end else if (ex_clear) begin
        ex_occ_q <= 1'b0;
      end

      if (ex_to_exd) begin
        exd_occ_q <= 1'b1;
        exd_tag_q <= ex_tag_q;
      end else if (exd_to_wb) begin
        exd_occ_q <= 1'b0;
      end

      if (ex_to_wb) begin
        wb_occ_q <= 1'b1;
        wb_tag_q <= ex_tag_q;
      end else if (exd_to_wb) begin
        wb_occ_q <= 1'b1;
        wb_tag_q <= exd_tag_q;
      end else if (wb_leave) begin
        wb_occ_q <= 1'b0;
      end

      // WB delay always drains after one cycle
      wbd_occ_q <= wb_to_wbd;
      if (wb_to_wbd) begin
        wbd_tag_q <= wb_tag_q;
      end
    end
  end

  a_wb_valid_occupied: assert property (@(posedge clk_i) disable iff (!rst_n)
    wb_i.valid |-> wb_occ_q);

endmodule

//--- trace_unit_top.sv
/* Trace unit top
   Capture, stage tracking and the retire buffer of the instruction tracer */
`timescale 1ns/10ps
`include "trace_macros.svh"

module trace_unit_top (
  input  logic                   clk_i,
  input  logic                   rst_n,
  input  trace_pkg::decode_evt_t decode_i,
  input  trace_pkg::ex_evt_t     ex_i,
  input  trace_pkg::mem_evt_t    mem_i,
  input  trace_pkg::wb_evt_t     wb_i,
  output trace_pkg::trace_rec_t  trace_o,
  output logic                   trace_valid_o,
  output logic                   overflow_o
);

  logic                                        new_valid;
  trace_pkg::tag_t                             new_tag;
  trace_pkg::trace_rec_t                       new_rec;
  trace_pkg::annot_t                           annot_ex, annot_wb, annot_mem;
  trace_pkg::annot_t [`TRACE_MARKS-1:0]         annot_mark;
  trace_pkg::tag_t [`TRACE_STAGES-1:0]          stage_tags;
  trace_pkg::stage_flags_t [`TRACE_STAGES-1:0] stage_flags;

  trace_capture u_capture (
    .clk_i       (clk_i),
    .rst_n       (rst_n),
    .decode_i    (decode_i),
    .new_valid_o (new_valid),
    .new_tag_o   (new_tag),
    .new_rec_o   (new_rec)
  );

  trace_stage_tracker u_tracker (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .new_valid_i   (new_valid),
    .new_tag_i     (new_tag),
    .ex_i          (ex_i),
    .mem_i         (mem_i),
    .wb_i          (wb_i),
    .stage_flags_i (stage_flags),
    .annot_ex_o    (annot_ex),
    .annot_wb_o    (annot_wb),
    .annot_mem_o   (annot_mem),
    .annot_mark_o  (annot_mark),
    .stage_tags_o  (stage_tags)
  );

  trace_retire_buffer u_buffer (
    .clk_i         (clk_i),
    .rst_n         (rst_n),
    .new_valid_i   (new_valid),
    .new_tag_i     (new_tag),
    .new_rec_i     (new_rec),
    .annot_ex_i    (annot_ex),
    .annot_wb_i    (annot_wb),
    .annot_mem_i   (annot_mem),
    .annot_mark_i  (annot_mark),
    .stage_tags_i  (stage_tags),
    .stage_flags_o (stage_flags),
    .trace_o       (trace_o),
    .trace_valid_o (trace_valid_o),
    .overflow_o    (overflow_o)
  );

endmodule
